//--- rv32i_slice.f
+incdir+common
common/rv_isa_pkg.sv
common/pipe_pkg.sv
decode/instr_decode.sv
execute/int_execute.sv
src/result_regfile.sv
src/rv32i_slice_top.sv
verif/tb_rv32i_slice.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the RV32I slice testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv32i_slice \
    -f rv32i_slice.f \
    -o tb_rv32i_slice

./obj_dir/tb_rv32i_slice

//--- verif/tb_rv32i_slice.sv
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module tb_rv32i_slice
    import rv_isa_pkg::*;
;

    localparam int num_instr = 2000;
    localparam int timeout_cycles = 6100;

    typedef struct packed {
        logic [31:0] due;
        logic        wb_valid;
        reg_idx_t    wb_rd;
        xword_t      wb_data;
        logic        br_taken;
        xword_t      br_target;
        logic        trap;
        xword_t      trap_tval;
    } outcome_t;

    logic     clk;
    logic     arst_n;
    logic     instr_valid;
    xword_t   instr_word;
    xword_t   instr_pc;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xword_t   wb_data;
    logic     br_taken;
    xword_t   br_target;
    logic     trap;
    xword_t   trap_tval;

    int          cyc;
    logic [15:0] lfsr_state;
    xword_t      mregs [0:31];
    outcome_t    exp_q [$];
    outcome_t    want;

    rv32i_slice_top UUT (
        .clk,
        .arst_n,
        .instr_valid,
        .instr_word,
        .instr_pc,
        .wb_valid,
        .wb_rd,
        .wb_data,
        .br_taken,
        .br_target,
        .trap,
        .trap_tval
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] build_instr();
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] f3;
        logic [31:0] imm;
        logic [31:0] raw;
        logic [31:0] sel;
        logic [6:0]  f7;
        logic [6:0]  opc;
        kind = rand_bits(4);
        rd = rand_bits(3);
        rs1 = rand_bits(3);
        rs2 = rand_bits(3);
        f3 = rand_bits(3);
        imm = rand_bits(12);
        raw = rand_bits(25);
        sel = rand_bits(2);
        f7 = 7'b0;
        case (kind[3:0])
            4'd0: begin
                // Load, store, fence and system are all outside the slice
                case (sel[1:0])
                    2'd0:    opc = 7'b0000011;
                    2'd1:    opc = 7'b0100011;
                    2'd2:    opc = 7'b0001111;
                    default: opc = 7'b1110011;
                endcase
                return {raw[24:0], opc};
            end
            4'd1: begin
                case (sel[1:0])
                    2'd0:    opc = `OPCODE_OP;
                    2'd1:    opc = `OPCODE_OP_IMM;
                    2'd2:    opc = `OPCODE_BRANCH;
                    default: opc = `OPCODE_JALR;
                endcase
                return {raw[24:0], opc};
            end
            4'd2, 4'd3, 4'd4, 4'd5: begin
                if ((f3[2:0] == 3'b000 || f3[2:0] == 3'b101) && sel[0]) f7 = `SUB_SRA_FUNCT7;
                return {f7, 2'b0, rs2[2:0], 2'b0, rs1[2:0], f3[2:0], 2'b0, rd[2:0], `OPCODE_OP};
            end
            4'd6, 4'd7, 4'd8: begin
                if (f3[2:0] == 3'b001) imm[11:5] = 7'b0;
                if (f3[2:0] == 3'b101) imm[11:5] = sel[0] ? `SUB_SRA_FUNCT7 : 7'b0;
                return {imm[11:0], 2'b0, rs1[2:0], f3[2:0], 2'b0, rd[2:0], `OPCODE_OP_IMM};
            end
            4'd9:  return {raw[19:0], 2'b0, rd[2:0], `OPCODE_LUI};
            4'd10: return {raw[19:0], 2'b0, rd[2:0], `OPCODE_AUIPC};
            4'd11, 4'd12, 4'd13: begin
                // Move the two undefined conditions onto LTU and GEU
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                return {imm[6:0], 2'b0, rs2[2:0], 2'b0, rs1[2:0], f3[2:0], imm[11:7],
                        `OPCODE_BRANCH};
            end
            4'd14: return {raw[19:0], 2'b0, rd[2:0], `OPCODE_JAL};
            default: begin
                return {imm[11:0], 2'b0, rs1[2:0], 3'b000, 2'b0, rd[2:0], `OPCODE_JALR};
            end
        endcase
    endfunction

    function automatic xword_t alu_ref(input logic [2:0] f3, input logic alt,
                                       input xword_t x, input xword_t y);
        case (f3)
            3'b000: return alt ? x - y : x + y;
            3'b001: return x << y[4:0];
            3'b010: return {31'b0, $signed(x) < $signed(y)};
            3'b011: return {31'b0, x < y};
            3'b100: return x ^ y;
            3'b101: begin
                if (alt) return $unsigned($signed(x) >>> y[4:0]);
                return x >> y[4:0];
            end
            3'b110: return x | y;
            default: return x & y;
        endcase
    endfunction

    // Expected outcome from the ISA rules and the model register state
    function automatic outcome_t model_instr(input xword_t w, input xword_t pc);
        outcome_t   o;
        xword_t     a;
        xword_t     b;
        xword_t     imm_i;
        xword_t     imm_u;
        xword_t     imm_b;
        xword_t     imm_j;
        xword_t     res;
        xword_t     tgt;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ill;
        logic       wr;
        logic       tk;
        o = '0;
        a = mregs[w[19:15]];
        b = mregs[w[24:20]];
        f3 = w[14:12];
        f7 = w[31:25];
        imm_i = 32'($signed(w[31:20]));
        imm_u = {w[31:12], 12'b0};
        imm_b = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        imm_j = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        res = '0;
        tgt = '0;
        ill = 1'b0;
        wr = 1'b0;
        tk = 1'b0;
        case (w[6:0])
            `OPCODE_OP: begin
                wr = 1'b1;
                if (f7 == 7'b0 || (f7 == `SUB_SRA_FUNCT7 && (f3 == 3'b000 || f3 == 3'b101)))
                    res = alu_ref(f3, f7[5], a, b);
                else
                    ill = 1'b1;
            end
            `OPCODE_OP_IMM: begin
                wr = 1'b1;
                if (f3 == 3'b001 && f7 != 7'b0) ill = 1'b1;
                if (f3 == 3'b101 && f7 != 7'b0 && f7 != `SUB_SRA_FUNCT7) ill = 1'b1;
                res = alu_ref(f3, f3 == 3'b101 && f7[5], a, imm_i);
            end
            `OPCODE_LUI: begin
                wr = 1'b1;
                res = imm_u;
            end
            `OPCODE_AUIPC: begin
                wr = 1'b1;
                res = pc + imm_u;
            end
            `OPCODE_BRANCH: begin
                tgt = pc + imm_b;
                case (f3)
                    3'b000:  tk = a == b;
                    3'b001:  tk = a != b;
                    3'b100:  tk = $signed(a) < $signed(b);
                    3'b101:  tk = $signed(a) >= $signed(b);
                    3'b110:  tk = a < b;
                    3'b111:  tk = a >= b;
                    default: ill = 1'b1;
                endcase
            end
            `OPCODE_JAL: begin
                wr = 1'b1;
                tk = 1'b1;
                res = pc + 32'd4;
                tgt = pc + imm_j;
            end
            `OPCODE_JALR: begin
                if (f3 != 3'b000) ill = 1'b1;
                wr = 1'b1;
                tk = 1'b1;
                res = pc + 32'd4;
                tgt = (a + imm_i) & ~32'd1;
            end
            default: ill = 1'b1;
        endcase
        o.wb_valid = !ill && wr && (w[11:7] != 5'd0);
        o.wb_rd = w[11:7];
        o.wb_data = res;
        o.br_taken = !ill && tk;
        o.br_target = tgt;
        o.trap = ill;
        o.trap_tval = w;
        return o;
    endfunction

    task automatic check_pulse(input string name, input logic got, input logic exp_bit);
        assert (got === exp_bit) else begin
            if (exp_bit) stop_with_error($sformatf("Missing %s pulse at cycle %0d", name, cyc));
            else stop_with_error($sformatf("Unexpected %s pulse at cycle %0d", name, cyc));
        end
    endtask

    task automatic compare_value(input string name, input xword_t got, input xword_t exp_val);
        assert (got === exp_val) else
            stop_with_error($sformatf("Mismatch %s: got %h expected %h at cycle %0d",
                                      name, got, exp_val, cyc));
    endtask

    // Compare every output cycle against the queued model outcome
    always @(negedge clk) begin
        if (cyc > 0) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) want = exp_q.pop_front();
            else want = '0;
            check_pulse("wb_valid", wb_valid, want.wb_valid);
            check_pulse("br_taken", br_taken, want.br_taken);
            check_pulse("trap", trap, want.trap);
            if (want.wb_valid) begin
                compare_value("wb_rd", 32'(wb_rd), 32'(want.wb_rd));
                compare_value("wb_data", wb_data, want.wb_data);
            end
            if (want.br_taken) compare_value("br_target", br_target, want.br_target);
            if (want.trap) compare_value("trap_tval", trap_tval, want.trap_tval);
        end
    end

    always @(negedge clk) begin
        if (cyc >= timeout_cycles)
            stop_with_error($sformatf("Run did not finish within %0d cycles", timeout_cycles));
    end

    initial begin
        outcome_t    slot_a;
        outcome_t    slot_b;
        outcome_t    fresh;
        logic [31:0] r;
        logic [1:0]  gap;
        logic        driving;
        int          issued;
        xword_t      next_pc;
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr_word = '0;
        instr_pc = '0;
        cyc = 0;
        lfsr_state = 16'd7389;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        slot_a = '0;
        slot_b = '0;
        gap = 2'd0;
        driving = 1'b0;
        issued = 0;
        next_pc = 32'h0000_1000;

        repeat (8) begin
            @(posedge clk);
            cyc = cyc + 1;
        end
        arst_n <= 1'b1;

        while (issued < num_instr || driving) begin
            @(posedge clk);
            cyc = cyc + 1;
            // The instruction sampled two edges ago writes back at this edge
            if (slot_b.wb_valid) mregs[slot_b.wb_rd] = slot_b.wb_data;
            fresh = '0;
            if (instr_valid) begin
                fresh = model_instr(instr_word, instr_pc);
                fresh.due = cyc + 2;
                exp_q.push_back(fresh);
            end
            slot_b = slot_a;
            slot_a = fresh;

            if (gap != 2'd0 || issued == num_instr) begin
                instr_valid <= 1'b0;
                driving = 1'b0;
                if (gap != 2'd0) gap = gap - 2'd1;
            end else begin
                instr_valid <= 1'b1;
                instr_word <= build_instr();
                instr_pc <= next_pc;
                next_pc = next_pc + 32'd4;
                issued = issued + 1;
                driving = 1'b1;
                r = rand_bits(2);
                gap = (r[1:0] == 2'b11) ? 2'd0 : r[1:0];
            end
        end

        repeat (4) begin
            @(posedge clk);
            cyc = cyc + 1;
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- src/rv32i_slice_top.sv
`timescale 1ns/10ps

module rv32i_slice_top
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     instr_valid,
    input  xword_t   instr_word,
    input  xword_t   instr_pc,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output xword_t   wb_data,
    output logic     br_taken,
    output xword_t   br_target,
    output logic     trap,
    output xword_t   trap_tval
);

    decoded_t     dec;
    exec_result_t ex;
    reg_idx_t     rs1_idx;
    reg_idx_t     rs2_idx;
    xword_t       rs1_val;
    xword_t       rs2_val;

    instr_decode u_decode (
        .clk,
        .arst_n,
        .instr_valid,
        .instr_word,
        .instr_pc,
        .dec
    );

    int_execute u_execute (
        .clk,
        .arst_n,
        .dec,
        .rs1_idx,
        .rs2_idx,
        .rs1_val,
        .rs2_val,
        .ex
    );

    result_regfile u_result (
        .clk,
        .arst_n,
        .rs1_idx,
        .rs2_idx,
        .rs1_val,
        .rs2_val,
        .ex,
        .wb_valid,
        .wb_rd,
        .wb_data,
        .br_taken,
        .br_target,
        .trap,
        .trap_tval
    );

endmodule

//--- src/result_regfile.sv
`timescale 1ns/10ps

module result_regfile
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  reg_idx_t     rs1_idx,
    input  reg_idx_t     rs2_idx,
    output xword_t       rs1_val,
    output xword_t       rs2_val,
    input  exec_result_t ex,
    output logic         wb_valid,
    output reg_idx_t     wb_rd,
    output xword_t       wb_data,
    output logic         br_taken,
    output xword_t       br_target,
    output logic         trap,
    output xword_t       trap_tval
);

    // x0 has no storage
    xword_t regs [1:31];
    logic   wr_en;

    assign wr_en = ex.valid && !ex.illegal && (ex.rd != '0);

    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            br_taken <= 1'b0;
            trap <= 1'b0;
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            wb_valid <= wr_en;
            br_taken <= ex.valid && !ex.illegal && ex.branch_taken;
            trap <= ex.valid && ex.illegal;
            if (wr_en) regs[ex.rd] <= ex.wdata;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd <= ex.rd;
        wb_data <= ex.wdata;
        br_target <= ex.target;
        trap_tval <= ex.tval;
    end

endmodule

//--- execute/int_execute.sv
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module int_execute
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  decoded_t     dec,
    output reg_idx_t     rs1_idx,
    output reg_idx_t     rs2_idx,
    input  xword_t       rs1_val,
    input  xword_t       rs2_val,
    output exec_result_t ex
);

    xword_t       op_a;
    xword_t       op_b;
    xword_t       alu_res;
    xword_t       target_sum;
    logic         cond_met;
    exec_result_t ex_next;

    assign rs1_idx = dec.rs1;
    assign rs2_idx = dec.rs2;

    assign op_a = dec.use_pc ? dec.pc : rs1_val;
    assign op_b = dec.use_imm ? dec.imm : rs2_val;

    // Branch and JAL base on pc, JALR on rs1
    assign target_sum = op_a + dec.imm;

    always_comb begin
        case (dec.alu_op)
            `ALU_SUB:  alu_res = op_a - op_b;
            `ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            `ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            `ALU_XOR:  alu_res = op_a ^ op_b;
            `ALU_OR:   alu_res = op_a | op_b;
            `ALU_AND:  alu_res = op_a & op_b;
            `ALU_SLL:  alu_res = op_a << op_b[4:0];
            `ALU_SRL:  alu_res = op_a >> op_b[4:0];
            `ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            default:   alu_res = op_a + op_b;
        endcase
    end

    // Compare always uses the register operands
    always_comb begin
        case (dec.cond)
            `COND_EQ:   cond_met = rs1_val == rs2_val;
            `COND_NE:   cond_met = rs1_val != rs2_val;
            `COND_LT:   cond_met = $signed(rs1_val) < $signed(rs2_val);
            `COND_GE:   cond_met = $signed(rs1_val) >= $signed(rs2_val);
            `COND_LTU:  cond_met = rs1_val < rs2_val;
            `COND_GEU:  cond_met = rs1_val >= rs2_val;
            `COND_TRUE: cond_met = 1'b1;
            default:    cond_met = 1'b0;
        endcase
    end

    always_comb begin
        ex_next.valid = dec.valid;
        ex_next.illegal = dec.illegal;
        ex_next.tval = dec.tval;
        ex_next.rd = dec.rd;
        ex_next.wdata = dec.is_jump ? dec.pc + 32'd4 : alu_res;
        ex_next.branch_taken = (dec.is_branch || dec.is_jump) && cond_met;
        // JALR drops bit 0 of its target
        ex_next.target = {target_sum[31:1], target_sum[0] & dec.use_pc};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex <= '0;
        end else begin
            ex <= ex_next;
        end
    end

endmodule

//--- decode/instr_decode.sv
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module instr_decode
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     instr_valid,
    input  xword_t   instr_word,
    input  xword_t   instr_pc,
    output decoded_t dec
);

    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    xword_t   i_imm;
    xword_t   u_imm;
    xword_t   b_imm;
    xword_t   j_imm;
    decoded_t dec_next;

    assign opcode = instr_word[6:0];
    assign funct3 = instr_word[14:12];
    assign funct7 = instr_word[31:25];

    assign i_imm = {{20{instr_word[31]}}, instr_word[31:20]};
    assign u_imm = {instr_word[31:12], 12'b0};
    assign b_imm = {{19{instr_word[31]}}, instr_word[31], instr_word[7],
                    instr_word[30:25], instr_word[11:8], 1'b0};
    assign j_imm = {{11{instr_word[31]}}, instr_word[31], instr_word[19:12],
                    instr_word[20], instr_word[30:21], 1'b0};

    always_comb begin
        dec_next = '0;
        dec_next.valid = instr_valid;
        dec_next.pc = instr_pc;
        dec_next.tval = instr_word;
        dec_next.alu_op = `ALU_ADD;
        dec_next.cond = `COND_EQ;

        case (opcode)
            `OPCODE_OP_IMM: begin
                dec_next.rs1 = instr_word[19:15];
                dec_next.rd = instr_word[11:7];
                dec_next.use_imm = 1'b1;
                dec_next.imm = i_imm;
                case (funct3)
                    3'b000: dec_next.alu_op = `ALU_ADD;
                    3'b010: dec_next.alu_op = `ALU_SLT;
                    3'b011: dec_next.alu_op = `ALU_SLTU;
                    3'b100: dec_next.alu_op = `ALU_XOR;
                    3'b110: dec_next.alu_op = `ALU_OR;
                    3'b111: dec_next.alu_op = `ALU_AND;
                    3'b001: begin
                        dec_next.alu_op = `ALU_SLL;
                        if (funct7[6:1] != 6'b0) dec_next.illegal = 1'b1;
                    end
                    default: begin
                        if (funct7[6:1] == 6'b0) dec_next.alu_op = `ALU_SRL;
                        else if ({funct7[6:1], 1'b0} == `SUB_SRA_FUNCT7) dec_next.alu_op = `ALU_SRA;
                        else dec_next.illegal = 1'b1;
                    end
                endcase
                // Shift amount is only 5 bits wide
                if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7[0]) dec_next.illegal = 1'b1;
            end

            `OPCODE_OP: begin
                dec_next.rs1 = instr_word[19:15];
                dec_next.rs2 = instr_word[24:20];
                dec_next.rd = instr_word[11:7];
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}:      dec_next.alu_op = `ALU_ADD;
                    {`SUB_SRA_FUNCT7, 3'b000}: dec_next.alu_op = `ALU_SUB;
                    {7'b0000000, 3'b010}:      dec_next.alu_op = `ALU_SLT;
                    {7'b0000000, 3'b011}:      dec_next.alu_op = `ALU_SLTU;
                    {7'b0000000, 3'b100}:      dec_next.alu_op = `ALU_XOR;
                    {7'b0000000, 3'b110}:      dec_next.alu_op = `ALU_OR;
                    {7'b0000000, 3'b111}:      dec_next.alu_op = `ALU_AND;
                    {7'b0000000, 3'b001}:      dec_next.alu_op = `ALU_SLL;
                    {7'b0000000, 3'b101}:      dec_next.alu_op = `ALU_SRL;
                    {`SUB_SRA_FUNCT7, 3'b101}: dec_next.alu_op = `ALU_SRA;
                    default:                   dec_next.illegal = 1'b1;
                endcase
            end

            // rs1 stays x0, so the ALU adds the immediate to zero
            `OPCODE_LUI: begin
                dec_next.rd = instr_word[11:7];
                dec_next.use_imm = 1'b1;
                dec_next.imm = u_imm;
            end

            `OPCODE_AUIPC: begin
                dec_next.rd = instr_word[11:7];
                dec_next.use_imm = 1'b1;
                dec_next.use_pc = 1'b1;
                dec_next.imm = u_imm;
            end

            `OPCODE_BRANCH: begin
                dec_next.rs1 = instr_word[19:15];
                dec_next.rs2 = instr_word[24:20];
                dec_next.use_pc = 1'b1;
                dec_next.is_branch = 1'b1;
                dec_next.imm = b_imm;
                case (funct3)
                    3'b000:  dec_next.cond = `COND_EQ;
                    3'b001:  dec_next.cond = `COND_NE;
                    3'b100:  dec_next.cond = `COND_LT;
                    3'b101:  dec_next.cond = `COND_GE;
                    3'b110:  dec_next.cond = `COND_LTU;
                    3'b111:  dec_next.cond = `COND_GEU;
                    default: dec_next.illegal = 1'b1;
                endcase
            end

            `OPCODE_JAL: begin
                dec_next.rd = instr_word[11:7];
                dec_next.use_pc = 1'b1;
                dec_next.is_jump = 1'b1;
                dec_next.cond = `COND_TRUE;
                dec_next.imm = j_imm;
            end

            `OPCODE_JALR: begin
                dec_next.rs1 = instr_word[19:15];
                dec_next.rd = instr_word[11:7];
                dec_next.use_imm = 1'b1;
                dec_next.is_jump = 1'b1;
                dec_next.cond = `COND_TRUE;
                dec_next.imm = i_imm;
                if (funct3 != 3'b000) dec_next.illegal = 1'b1;
            end

            default: dec_next.illegal = 1'b1;
        endcase

        if (dec_next.illegal) dec_next.rd = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec <= '0;
        end else begin
            dec <= dec_next;
        end
    end

endmodule

//--- common/pipe_pkg.sv
package pipe_pkg;

    import rv_isa_pkg::*;

    // Decode-stage register
    typedef struct packed {
        logic     valid;
        logic     illegal;
        xword_t   pc;
        xword_t   tval;
        reg_idx_t rs1;
        reg_idx_t rs2;
        // Zero when nothing is written back
        reg_idx_t rd;
        alu_op_t  alu_op;
        cond_t    cond;
        logic     use_imm;
        logic     use_pc;
        logic     is_branch;
        logic     is_jump;
        xword_t   imm;
    } decoded_t;

    // Execute-stage register
    typedef struct packed {
        logic     valid;
        logic     illegal;
        xword_t   tval;
        reg_idx_t rd;
        xword_t   wdata;
        logic     branch_taken;
        xword_t   target;
    } exec_result_t;

endpackage

//--- common/rv_isa_pkg.sv
`include "rv32i_consts.svh"

package rv_isa_pkg;

    // Data and address word
    typedef logic [`XLEN_W-1:0] xword_t;

    // Architectural register index
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Execute-stage controls
    typedef logic [3:0] alu_op_t;
    typedef logic [2:0] cond_t;

endpackage

//--- common/rv32i_consts.svh
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

`define XLEN_W              32
`define REG_IDX_W           5

// Base opcodes kept in the slice
`define OPCODE_OP           7'b0110011
`define OPCODE_OP_IMM       7'b0010011
`define OPCODE_LUI          7'b0110111
`define OPCODE_AUIPC        7'b0010111
`define OPCODE_BRANCH       7'b1100011
`define OPCODE_JAL          7'b1101111
`define OPCODE_JALR         7'b1100111

// Selects SUB and SRA
`define SUB_SRA_FUNCT7      7'b0100000

`define ALU_ADD             4'd0
`define ALU_SUB             4'd1
`define ALU_SLT             4'd2
`define ALU_SLTU            4'd3
`define ALU_XOR             4'd4
`define ALU_OR              4'd5
`define ALU_AND             4'd6
`define ALU_SLL             4'd7
`define ALU_SRL             4'd8
`define ALU_SRA             4'd9

// Branch conditions follow the branch funct3 encoding and TRUE takes a free slot
`define COND_EQ             3'b000
`define COND_NE             3'b001
`define COND_TRUE           3'b010
`define COND_LT             3'b100
`define COND_GE             3'b101
`define COND_LTU            3'b110
`define COND_GEU            3'b111

`endif
